// ==== Makefile ====
# Verilator simulation of the Tetris display

VERILATOR  ?= verilator
TOP        ?= tetris_display_tb
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/100ps
VFLAGS     ?= --binary --timing --assert --timescale $(TIMESCALE)
LINT_FLAGS ?= --lint-only --timing -Wall --timescale $(TIMESCALE)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "TESTBENCH PASSED" $(LOG); then \
	  echo "Simulation ended without a verdict, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/banner_renderer.sv ====
`timescale 1ns/100ps

module banner_renderer (
  input  tetris_pkg::pixel_pos_t   pos,
  output tetris_pkg::pixel_color_t color
);
  import tetris_pkg::*;

  // Five font columns plus one blank
  localparam int CHAR_COLS = 6;
  localparam int FONT_ROWS = 7;
  localparam int BANNER_X1 = BANNER_X0 + BANNER_W * CHAR_COLS * FONT_SCALE;
  localparam int BANNER_Y1 = BANNER_Y0 + FONT_ROWS * FONT_SCALE;

  //////////////////////////////
  // Glyph ROM
  //////////////////////////////

  // Top row in the MSBs, leftmost column first
  localparam logic [34:0] GLYPH_T = {5'b11111, 5'b00100, 5'b00100, 5'b00100,
                                     5'b00100, 5'b00100, 5'b00100};
  localparam logic [34:0] GLYPH_E = {5'b11111, 5'b10000, 5'b10000, 5'b11110,
                                     5'b10000, 5'b10000, 5'b11111};
  localparam logic [34:0] GLYPH_R = {5'b11110, 5'b10001, 5'b10001, 5'b11110,
                                     5'b10100, 5'b10010, 5'b10001};
  localparam logic [34:0] GLYPH_I = {5'b01110, 5'b00100, 5'b00100, 5'b00100,
                                     5'b00100, 5'b00100, 5'b01110};
  localparam logic [34:0] GLYPH_S = {5'b01111, 5'b10000, 5'b10000, 5'b01110,
                                     5'b00001, 5'b00001, 5'b11110};

  logic        in_banner;
  coord_t      fx;
  coord_t      fy;
  logic [2:0]  char_idx;
  logic [2:0]  char_col;
  logic [34:0] glyph;
  logic        pix_on;

  // Position in font cells
  assign in_banner = (pos.x >= coord_t'(BANNER_X0)) && (pos.x < coord_t'(BANNER_X1)) &&
                     (pos.y >= coord_t'(BANNER_Y0)) && (pos.y < coord_t'(BANNER_Y1));
  assign fx = (pos.x - coord_t'(BANNER_X0)) / coord_t'(FONT_SCALE);
  assign fy = (pos.y - coord_t'(BANNER_Y0)) / coord_t'(FONT_SCALE);

  // Which letter and which column of it
  assign char_idx = 3'(fx / coord_t'(CHAR_COLS));
  assign char_col = 3'(fx % coord_t'(CHAR_COLS));

  // T E T R I S
  always_comb begin
    case (char_idx)
      3'd0:    glyph = GLYPH_T;
      3'd1:    glyph = GLYPH_E;
      3'd2:    glyph = GLYPH_T;
      3'd3:    glyph = GLYPH_R;
      3'd4:    glyph = GLYPH_I;
      3'd5:    glyph = GLYPH_S;
      default: glyph = '0;
    endcase
  end

  // Spacing column never lit
  always_comb begin
    pix_on = 1'b0;
    if (in_banner && (char_col < 3'd5)) begin
      pix_on = glyph[34 - (int'(fy) * 5 + int'(char_col))];
    end
  end

  assign color = pix_on ? BANNER_COLOR : '0;

endmodule

// ==== logic/grid_renderer.sv ====
`timescale 1ns/100ps

module grid_renderer (
  input  tetris_pkg::pixel_pos_t   pos,
  input  tetris_pkg::board_t       board,
  output tetris_pkg::pixel_color_t color
);
  import tetris_pkg::*;

  // Board rectangle, end bounds exclusive
  localparam int GRID_X1    = GRID_X0 + GRID_COLS * CELL_PX;
  localparam int GRID_Y1    = GRID_Y0 + GRID_ROWS * CELL_PX;
  localparam int CELL_SHIFT = $clog2(CELL_PX);

  // Outer edge of the white ring
  localparam int RING_X0 = GRID_X0 - BORDER_PX;
  localparam int RING_X1 = GRID_X1 + BORDER_PX;
  localparam int RING_Y0 = GRID_Y0 - BORDER_PX;
  localparam int RING_Y1 = GRID_Y1 + BORDER_PX;

  localparam pixel_color_t WHITE = 3'd7;

  logic       in_board;
  logic       in_ring;
  coord_t     dx;
  coord_t     dy;
  logic [4:0] row;
  logic [3:0] col;

  //////////////////////////////
  // Region decode
  //////////////////////////////

  assign in_board = (pos.x >= coord_t'(GRID_X0)) && (pos.x < coord_t'(GRID_X1)) &&
                    (pos.y >= coord_t'(GRID_Y0)) && (pos.y < coord_t'(GRID_Y1));

  // Ring box includes the board, board wins below
  assign in_ring = (pos.x >= coord_t'(RING_X0)) && (pos.x < coord_t'(RING_X1)) &&
                   (pos.y >= coord_t'(RING_Y0)) && (pos.y < coord_t'(RING_Y1));

  // Offset into the board
  assign dx = pos.x - coord_t'(GRID_X0);
  assign dy = pos.y - coord_t'(GRID_Y0);

  // Cell index, divide by cell size
  assign col = dx[CELL_SHIFT +: 4];
  assign row = dy[CELL_SHIFT +: 5];

  //////////////////////////////
  // Color select
  //////////////////////////////

  always_comb begin
    if (in_board) begin
      color = board[row][col];
    end else if (in_ring) begin
      color = WHITE;
    end else begin
      // Transparent outside the board
      color = '0;
    end
  end

endmodule

// ==== logic/score_renderer.sv ====
`timescale 1ns/100ps

module score_renderer (
  input  tetris_pkg::pixel_pos_t   pos,
  input  tetris_pkg::score_t       score,
  output tetris_pkg::pixel_color_t color
);
  import tetris_pkg::*;

  localparam int DIGIT_PITCH = DIGIT_W + DIGIT_GAP;
  localparam int HALF_H      = DIGIT_H / 2;
  // Middle bar centered on row 11
  localparam int G_MID       = 11;

  score_t     rem;
  logic [3:0] hund;
  logic [3:0] tens;
  logic [3:0] units;
  logic [2:0][3:0] digits;

  logic       in_y;
  logic       in_digit;
  logic [3:0] digit_val;
  coord_t     lx;
  coord_t     ly;
  logic [6:0] seg_on;
  logic [6:0] seg_hit;

  // Segment order {g,f,e,d,c,b,a}
  function automatic logic [6:0] seg7(input logic [3:0] d);
    case (d)
      4'd0:    seg7 = 7'h3F;
      4'd1:    seg7 = 7'h06;
      4'd2:    seg7 = 7'h5B;
      4'd3:    seg7 = 7'h4F;
      4'd4:    seg7 = 7'h66;
      4'd5:    seg7 = 7'h6D;
      4'd6:    seg7 = 7'h7D;
      4'd7:    seg7 = 7'h07;
      4'd8:    seg7 = 7'h7F;
      4'd9:    seg7 = 7'h6F;
      default: seg7 = 7'h00;
    endcase
  endfunction

  //////////////////////////////
  // Binary to decimal
  //////////////////////////////

  always_comb begin
    rem  = score;
    hund = '0;
    if (rem >= 8'd200) begin
      hund = 4'd2;
      rem  = rem - 8'd200;
    end else if (rem >= 8'd100) begin
      hund = 4'd1;
      rem  = rem - 8'd100;
    end
    // At most nine tens left
    tens = '0;
    for (int i = 0; i < 9; i++) begin
      if (rem >= 8'd10) begin
        rem  = rem - 8'd10;
        tens = tens + 4'd1;
      end
    end
    units = rem[3:0];
  end

  // Hundreds leftmost
  assign digits[0] = hund;
  assign digits[1] = tens;
  assign digits[2] = units;

  //////////////////////////////
  // Digit placement
  //////////////////////////////

  assign in_y = (pos.y >= coord_t'(SCORE_Y0)) && (pos.y < coord_t'(SCORE_Y0 + DIGIT_H));
  assign ly   = pos.y - coord_t'(SCORE_Y0);

  always_comb begin
    in_digit  = 1'b0;
    digit_val = '0;
    lx        = '0;
    for (int k = 0; k < 3; k++) begin
      if ((pos.x >= coord_t'(SCORE_X0 + k * DIGIT_PITCH)) &&
          (pos.x <  coord_t'(SCORE_X0 + k * DIGIT_PITCH + DIGIT_W))) begin
        in_digit  = in_y;
        digit_val = digits[k];
        lx        = pos.x - coord_t'(SCORE_X0 + k * DIGIT_PITCH);
      end
    end
  end

  //////////////////////////////
  // Segment geometry
  //////////////////////////////

  assign seg_hit[0] = (ly < coord_t'(SEG_T));
  assign seg_hit[1] = (lx >= coord_t'(DIGIT_W - SEG_T)) && (ly < coord_t'(HALF_H));
  assign seg_hit[2] = (lx >= coord_t'(DIGIT_W - SEG_T)) && (ly >= coord_t'(HALF_H));
  assign seg_hit[3] = (ly >= coord_t'(DIGIT_H - SEG_T));
  assign seg_hit[4] = (lx < coord_t'(SEG_T)) && (ly >= coord_t'(HALF_H));
  assign seg_hit[5] = (lx < coord_t'(SEG_T)) && (ly < coord_t'(HALF_H));
  assign seg_hit[6] = (ly >= coord_t'(G_MID - SEG_T / 2)) &&
                      (ly <= coord_t'(G_MID + SEG_T / 2));

  assign seg_on = seg7(digit_val);
  assign color  = (in_digit && |(seg_on & seg_hit)) ? SCORE_COLOR : '0;

endmodule

// ==== logic/score_ticker.sv ====
`timescale 1ns/100ps

module score_ticker #(
  parameter int TICK_DIV = 100
) (
  input  logic               onehuzz,
  input  logic               reset,
  output tetris_pkg::score_t score
);

  localparam int DIV_W = $clog2(TICK_DIV + 1);

  logic [DIV_W-1:0] div_cnt;
  logic             tick;

  //////////////////////////////
  // Tick divider
  //////////////////////////////

  // Counts 0 .. TICK_DIV-1, tick on the last count
  // so the first one lands TICK_DIV cycles after reset
  assign tick = (div_cnt == DIV_W'(TICK_DIV - 1));

  always_ff @(posedge onehuzz, posedge reset) begin
    if (reset) begin
      div_cnt <= '0;
    end else if (tick) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + DIV_W'(1);
    end
  end

  //////////////////////////////
  // Score register
  //////////////////////////////

  // Test pattern score, sticks at the top value
  always_ff @(posedge onehuzz, posedge reset) begin
    if (reset) begin
      score <= '0;
    end else if (tick && (score != '1)) begin
      score <= score + 8'd1;
    end
  end

endmodule

// ==== logic/tetris_display.sv ====
`timescale 1ns/100ps

module tetris_display #(
  parameter int TICK_DIV = 100
) (
  input  logic               onehuzz,
  input  logic               reset,
  input  tetris_pkg::board_t board,
  output logic               hsync,
  output logic               vsync,
  output logic               red,
  output logic               green,
  output logic               blue,
  output tetris_pkg::score_t score
);
  import tetris_pkg::*;

  pixel_pos_t   pos;
  logic         hsync_raw;
  logic         vsync_raw;
  pixel_color_t grid_color;
  pixel_color_t score_color;
  pixel_color_t banner_color;
  pixel_color_t final_color;
  pixel_color_t rgb_q;

  //////////////////////////////
  // Blocks
  //////////////////////////////

  vga_timing u_timing (
    .onehuzz   (onehuzz),
    .reset     (reset),
    .pos       (pos),
    .hsync_raw (hsync_raw),
    .vsync_raw (vsync_raw)
  );

  score_ticker #(
    .TICK_DIV (TICK_DIV)
  ) u_ticker (
    .onehuzz (onehuzz),
    .reset   (reset),
    .score   (score)
  );

  grid_renderer u_grid (
    .pos   (pos),
    .board (board),
    .color (grid_color)
  );

  score_renderer u_score (
    .pos   (pos),
    .score (score),
    .color (score_color)
  );

  banner_renderer u_banner (
    .pos   (pos),
    .color (banner_color)
  );

  //////////////////////////////
  // Layer merge
  //////////////////////////////

  // Banner over score over board, black in blanking
  always_comb begin
    if (!pos.active) begin
      final_color = '0;
    end else if (banner_color != '0) begin
      final_color = banner_color;
    end else if (score_color != '0) begin
      final_color = score_color;
    end else begin
      final_color = grid_color;
    end
  end

  // One stage for color and syncs alike
  always_ff @(posedge onehuzz, posedge reset) begin
    if (reset) begin
      rgb_q <= '0;
      hsync <= 1'b1;
      vsync <= 1'b1;
    end else begin
      rgb_q <= final_color;
      hsync <= hsync_raw;
      vsync <= vsync_raw;
    end
  end

  assign red   = rgb_q[2];
  assign green = rgb_q[1];
  assign blue  = rgb_q[0];

endmodule

// ==== logic/tetris_pkg.sv ====
package tetris_pkg;

  //////////////////////////////
  // Basic types
  //////////////////////////////

  // One bit each for red, green, blue
  typedef logic [2:0] pixel_color_t;
  typedef logic [9:0] coord_t;
  typedef logic [7:0] score_t;

  // Current scan position, shared by all renderers
  typedef struct packed {
    coord_t x;
    coord_t y;
    logic   active;
  } pixel_pos_t;

  //////////////////////////////
  // 640x480 frame timing
  //////////////////////////////

  localparam int H_ACTIVE = 640;
  localparam int H_FRONT  = 16;
  localparam int H_SYNC   = 96;
  localparam int H_BACK   = 48;
  localparam int H_TOTAL  = 800;

  localparam int V_ACTIVE = 480;
  localparam int V_FRONT  = 10;
  localparam int V_SYNC   = 2;
  localparam int V_BACK   = 33;
  localparam int V_TOTAL  = 525;

  //////////////////////////////
  // Layout
  //////////////////////////////

  // Board placement, 16 px cells
  localparam int CELL_PX   = 16;
  localparam int GRID_COLS = 10;
  localparam int GRID_ROWS = 20;
  localparam int GRID_X0   = 240;
  localparam int GRID_Y0   = 96;
  localparam int BORDER_PX = 2;

  // Row 0 on top, column 0 on the left
  typedef pixel_color_t [GRID_ROWS-1:0][GRID_COLS-1:0] board_t;

  // Score digits to the right of the board
  localparam int SCORE_X0  = 440;
  localparam int SCORE_Y0  = 96;
  localparam int DIGIT_W   = 16;
  localparam int DIGIT_H   = 24;
  localparam int DIGIT_GAP = 4;
  localparam int SEG_T     = 3;
  localparam pixel_color_t SCORE_COLOR = 3'd2;

  // Title banner above the board
  localparam int BANNER_X0 = 200;
  localparam int BANNER_Y0 = 24;
  localparam int FONT_SCALE = 4;
  localparam int BANNER_W  = 6;
  localparam pixel_color_t BANNER_COLOR = 3'd5;

endpackage

// ==== logic/vga_timing.sv ====
`timescale 1ns/100ps

module vga_timing (
  input  logic                   onehuzz,
  input  logic                   reset,
  output tetris_pkg::pixel_pos_t pos,
  output logic                   hsync_raw,
  output logic                   vsync_raw
);
  import tetris_pkg::*;

  // Sync windows, counted from the start of the line / frame
  localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
  localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
  localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
  localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

  coord_t h_cnt;
  coord_t v_cnt;
  logic   h_last;
  logic   v_last;

  //////////////////////////////
  // Pixel counters
  //////////////////////////////

  // End of line and end of frame
  assign h_last = (h_cnt == coord_t'(H_TOTAL - 1));
  assign v_last = (v_cnt == coord_t'(V_TOTAL - 1));

  // Horizontal wraps every 800 clocks
  always_ff @(posedge onehuzz, posedge reset) begin
    if (reset) begin
      h_cnt <= '0;
    end else if (h_last) begin
      h_cnt <= '0;
    end else begin
      h_cnt <= h_cnt + coord_t'(1);
    end
  end

  // Vertical steps once per line
  always_ff @(posedge onehuzz, posedge reset) begin
    if (reset) begin
      v_cnt <= '0;
    end else if (h_last) begin
      if (v_last) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + coord_t'(1);
      end
    end
  end

  //////////////////////////////
  // Decode
  //////////////////////////////

  assign pos.x      = h_cnt;
  assign pos.y      = v_cnt;
  assign pos.active = (h_cnt < coord_t'(H_ACTIVE)) && (v_cnt < coord_t'(V_ACTIVE));

  // Both syncs active low
  assign hsync_raw = !((h_cnt >= coord_t'(H_SYNC_START)) &&
                       (h_cnt <  coord_t'(H_SYNC_END)));
  assign vsync_raw = !((v_cnt >= coord_t'(V_SYNC_START)) &&
                       (v_cnt <  coord_t'(V_SYNC_END)));

endmodule

// ==== sim.f ====
logic/tetris_pkg.sv
logic/vga_timing.sv
logic/score_ticker.sv
logic/grid_renderer.sv
logic/score_renderer.sv
logic/banner_renderer.sv
logic/tetris_display.sv
sim/tetris_display_chk.sv
sim/tetris_display_tb.sv

// ==== sim/tetris_display_chk.sv ====
`timescale 1ns/100ps

module tetris_display_chk (
  input logic onehuzz,
  input logic reset,
  input logic hsync_raw,
  input logic vsync_raw
);
  import tetris_pkg::*;

  // Length of the current low pulse
  int h_low;
  int v_low;

  // Number of failed assertions
  int fail_count = 0;

  always_ff @(posedge onehuzz, posedge reset) begin
    if (reset) begin
      h_low <= 0;
      v_low <= 0;
    end else begin
      h_low <= hsync_raw ? 0 : h_low + 1;
      v_low <= vsync_raw ? 0 : v_low + 1;
    end
  end

  //////////////////////////////
  // Sync widths
  //////////////////////////////

  // Width seen when the sync goes high again
  assert property (@(posedge onehuzz) disable iff (reset)
    $rose(hsync_raw) |-> (h_low == H_SYNC))
    else begin
      $error("hsync low for %0d cycles", h_low);
      fail_count++;
    end

  // Two full lines
  assert property (@(posedge onehuzz) disable iff (reset)
    $rose(vsync_raw) |-> (v_low == V_SYNC * H_TOTAL))
    else begin
      $error("vsync low for %0d cycles", v_low);
      fail_count++;
    end

  // No pulse runs past its width
  assert property (@(posedge onehuzz) disable iff (reset)
    (h_low <= H_SYNC) && (v_low <= V_SYNC * H_TOTAL))
    else begin
      $error("sync pulse too long");
      fail_count++;
    end

endmodule

bind vga_timing tetris_display_chk u_chk (
  .onehuzz   (onehuzz),
  .reset     (reset),
  .hsync_raw (hsync_raw),
  .vsync_raw (vsync_raw)
);

// ==== sim/tetris_display_tb.sv ====
`timescale 1ns/100ps

module tetris_display_tb;
  import tetris_pkg::*;

  // Short divider so the score saturates inside the first frame
  localparam int TICK_DIV    = 997;
  localparam int RUN_FRAMES  = 2;
  // 2.2 frames of 800x525 clocks
  localparam int CYCLE_LIMIT = 924000;

  logic   onehuzz;
  logic   reset;
  board_t board;
  logic   hsync;
  logic   vsync;
  logic   red;
  logic   green;
  logic   blue;
  score_t score;

  // Reference model state
  int           mx;
  int           my;
  int           mdiv;
  int           frames;
  score_t       mscore;
  logic         exp_hsync;
  logic         exp_vsync;
  pixel_color_t exp_color;
  // Position the current outputs belong to
  int           out_x;
  int           out_y;

  int cycles = 0;
  int checks = 0;
  int errors = 0;

  tetris_display #(
    .TICK_DIV (TICK_DIV)
  ) u_dut (
    .onehuzz (onehuzz),
    .reset   (reset),
    .board   (board),
    .hsync   (hsync),
    .vsync   (vsync),
    .red     (red),
    .green   (green),
    .blue    (blue),
    .score   (score)
  );

  always #4 onehuzz = ~onehuzz;

  //////////////////////////////
  // Pixel model
  //////////////////////////////

  // Banner font, top row first, leftmost column in the MSB
  function automatic logic [34:0] letter_bits(input int idx);
    case (idx)
      0, 2:    letter_bits = {5'b11111, 5'b00100, 5'b00100, 5'b00100,
                              5'b00100, 5'b00100, 5'b00100};
      1:       letter_bits = {5'b11111, 5'b10000, 5'b10000, 5'b11110,
                              5'b10000, 5'b10000, 5'b11111};
      3:       letter_bits = {5'b11110, 5'b10001, 5'b10001, 5'b11110,
                              5'b10100, 5'b10010, 5'b10001};
      4:       letter_bits = {5'b01110, 5'b00100, 5'b00100, 5'b00100,
                              5'b00100, 5'b00100, 5'b01110};
      5:       letter_bits = {5'b01111, 5'b10000, 5'b10000, 5'b01110,
                              5'b00001, 5'b00001, 5'b11110};
      default: letter_bits = '0;
    endcase
  endfunction

  // TETRIS, six font columns per letter, scaled by four
  function automatic pixel_color_t banner_px(input int x, input int y);
    int          fx;
    int          fy;
    int          col;
    logic [34:0] bits;
    logic [4:0]  row_bits;
    banner_px = '0;
    if (x >= BANNER_X0 && x < BANNER_X0 + BANNER_W * 6 * FONT_SCALE &&
        y >= BANNER_Y0 && y < BANNER_Y0 + 7 * FONT_SCALE) begin
      fx       = (x - BANNER_X0) / FONT_SCALE;
      fy       = (y - BANNER_Y0) / FONT_SCALE;
      col      = fx % 6;
      bits     = letter_bits(fx / 6);
      row_bits = bits[(6 - fy) * 5 +: 5];
      if (col < 5 && row_bits[4 - col]) begin
        banner_px = BANNER_COLOR;
      end
    end
  endfunction

  // Segments {a,b,c,d,e,f,g}, a in bit 6
  function automatic logic [6:0] digit_segs(input int d);
    case (d)
      0:       digit_segs = 7'b1111110;
      1:       digit_segs = 7'b0110000;
      2:       digit_segs = 7'b1101101;
      3:       digit_segs = 7'b1111001;
      4:       digit_segs = 7'b0110011;
      5:       digit_segs = 7'b1011011;
      6:       digit_segs = 7'b1011111;
      7:       digit_segs = 7'b1110000;
      8:       digit_segs = 7'b1111111;
      9:       digit_segs = 7'b1111011;
      default: digit_segs = 7'b0000000;
    endcase
  endfunction

  function automatic pixel_color_t score_px(input int x, input int y, input int s);
    int         k;
    int         lx;
    int         ly;
    int         val;
    logic [6:0] hit;
    score_px = '0;
    ly = y - SCORE_Y0;
    for (k = 0; k < 3; k++) begin
      lx = x - (SCORE_X0 + k * (DIGIT_W + DIGIT_GAP));
      if (lx >= 0 && lx < DIGIT_W && ly >= 0 && ly < DIGIT_H) begin
        // Hundreds, tens, units from left to right
        case (k)
          0:       val = s / 100;
          1:       val = (s / 10) % 10;
          default: val = s % 10;
        endcase
        hit[6] = (ly < SEG_T);
        hit[5] = (lx >= DIGIT_W - SEG_T) && (ly < DIGIT_H / 2);
        hit[4] = (lx >= DIGIT_W - SEG_T) && (ly >= DIGIT_H / 2);
        hit[3] = (ly >= DIGIT_H - SEG_T);
        hit[2] = (lx < SEG_T) && (ly >= DIGIT_H / 2);
        hit[1] = (lx < SEG_T) && (ly < DIGIT_H / 2);
        // Middle bar, rows 10 to 12
        hit[0] = (ly >= 10) && (ly <= 12);
        if ((digit_segs(val) & hit) != 7'b0) begin
          score_px = SCORE_COLOR;
        end
      end
    end
  endfunction

  function automatic pixel_color_t grid_px(input int x, input int y, input board_t b);
    int row;
    int col;
    grid_px = '0;
    if (x >= GRID_X0 && x < GRID_X0 + GRID_COLS * CELL_PX &&
        y >= GRID_Y0 && y < GRID_Y0 + GRID_ROWS * CELL_PX) begin
      row     = (y - GRID_Y0) / CELL_PX;
      col     = (x - GRID_X0) / CELL_PX;
      grid_px = b[row][col];
    end else if (x >= GRID_X0 - BORDER_PX && x < GRID_X0 + GRID_COLS * CELL_PX + BORDER_PX &&
                 y >= GRID_Y0 - BORDER_PX && y < GRID_Y0 + GRID_ROWS * CELL_PX + BORDER_PX) begin
      // White ring
      grid_px = 3'd7;
    end
  endfunction

  // Banner over score over board, black outside active video
  function automatic pixel_color_t pixel_model(input int x, input int y, input board_t b,
                                               input int s);
    if (x >= H_ACTIVE || y >= V_ACTIVE) begin
      pixel_model = '0;
    end else if (banner_px(x, y) != '0) begin
      pixel_model = banner_px(x, y);
    end else if (score_px(x, y, s) != '0) begin
      pixel_model = score_px(x, y, s);
    end else begin
      pixel_model = grid_px(x, y, b);
    end
  endfunction

  function automatic board_t random_board();
    board_t b;
    int     r;
    int     c;
    for (r = 0; r < GRID_ROWS; r++) begin
      for (c = 0; c < GRID_COLS; c++) begin
        b[r][c] = pixel_color_t'($urandom % 8);
      end
    end
    random_board = b;
  endfunction

  task automatic check_value(input int actual, input int expected, input string what);
    checks++;
    if (actual != expected) begin
      errors++;
      $display("ERROR %0t ns: %s at x=%0d y=%0d, got %0d expected %0d",
               $time, what, out_x, out_y, actual, expected);
    end
  endtask

  //////////////////////////////
  // Model counters
  //////////////////////////////

  // Outputs of cycle n are the values for the position held in cycle n
  always @(posedge onehuzz or posedge reset) begin
    if (reset) begin
      mx        <= 0;
      my        <= 0;
      mdiv      <= 0;
      frames    <= 0;
      mscore    <= '0;
      exp_hsync <= 1'b1;
      exp_vsync <= 1'b1;
      exp_color <= '0;
      out_x     <= 0;
      out_y     <= 0;
    end else begin
      exp_hsync <= !(mx >= H_ACTIVE + H_FRONT && mx < H_ACTIVE + H_FRONT + H_SYNC);
      exp_vsync <= !(my >= V_ACTIVE + V_FRONT && my < V_ACTIVE + V_FRONT + V_SYNC);
      exp_color <= pixel_model(mx, my, board, int'(mscore));
      out_x     <= mx;
      out_y     <= my;
      if (mx == H_TOTAL - 1) begin
        mx <= 0;
        if (my == V_TOTAL - 1) begin
          my     <= 0;
          frames <= frames + 1;
        end else begin
          my <= my + 1;
        end
      end else begin
        mx <= mx + 1;
      end
      // Tick every TICK_DIV cycles, score sticks at 255
      if (mdiv == TICK_DIV - 1) begin
        mdiv <= 0;
        if (mscore != 8'd255) begin
          mscore <= mscore + 8'd1;
        end
      end else begin
        mdiv <= mdiv + 1;
      end
    end
  end

  //////////////////////////////
  // Stimulus and checks
  //////////////////////////////

  // Outputs settle after the rising edge
  always @(negedge onehuzz) begin
    if (!reset) begin
      check_value(int'(hsync), int'(exp_hsync), "hsync");
      check_value(int'(vsync), int'(exp_vsync), "vsync");
      check_value(int'({red, green, blue}), int'(exp_color), "color");
      check_value(int'(score), int'(mscore), "score");
    end
  end

  always @(posedge onehuzz) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    onehuzz = 1'b0;
    reset   = 1'b1;
    void'($urandom(5));
    board   = random_board();
    repeat (5) @(posedge onehuzz);
    reset <= 1'b0;
    // Output registers still hold their reset values
    @(negedge onehuzz);
    check_value(int'(hsync), 1, "hsync after reset");
    check_value(int'(vsync), 1, "vsync after reset");
    check_value(int'({red, green, blue}), 0, "color after reset");
    check_value(int'(score), 0, "score after reset");
    // New board once per frame, during pixel (0,0)
    while (frames != RUN_FRAMES) begin
      @(posedge onehuzz);
      if (mx == 0 && my == 0) begin
        board <= random_board();
      end
    end
    check_value(int'(score), 255, "final score");
    errors += u_dut.u_timing.u_chk.fail_count;
    $display("Checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
